//--- Bender.yml
package:
  name: rvCore

sources:
  - include_dirs:
      - design
    files:
      - design/rvCorePkg.sv
      - design/coreIfs.sv
      - design/instrDecoder.sv
      - design/aluUnit.sv
      - design/rvDatapath.sv
      - design/coreController.sv
      - design/perfCounter.sv
      - design/rvCoreTop.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/tbClock.sv
      - tests/apbMemModel.sv
      - tests/rvCoreTb.sv

//--- design/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defines.svh"

module aluUnit import rvCorePkg::*; (
    input  xlenT  opA,
    input  xlenT  opB,
    input  aluOpT op,
    input  logic  isWord,
    output xlenT  result,
    output logic  eq,
    output logic  lt,
    output logic  ltu
);
    xlenT       srcA;
    xlenT       raw;
    logic [5:0] shamt;

    // word shifts see only the low 32 bits of a
    always_comb begin
        srcA = opA;
        if (isWord)
            srcA = (op == aluSra) ? {{32{opA[31]}}, opA[31:0]} : {32'b0, opA[31:0]};
    end

    assign shamt = isWord ? {1'b0, opB[4:0]} : opB[5:0];

    always_comb begin
        case (op)
            aluAdd:  raw = srcA + opB;
            aluSub:  raw = srcA - opB;
            aluSll:  raw = srcA << shamt;
            aluSlt:  raw = {{(`XLEN-1){1'b0}}, lt};
            aluSltu: raw = {{(`XLEN-1){1'b0}}, ltu};
            aluXor:  raw = srcA ^ opB;
            aluSrl:  raw = srcA >> shamt;
            aluSra:  raw = $signed(srcA) >>> shamt;
            aluOr:   raw = srcA | opB;
            aluAnd:  raw = srcA & opB;
            default: raw = opB; // passB for lui
        endcase
    end

    assign result = isWord ? {{32{raw[31]}}, raw[31:0]} : raw;

    // branch compares
    assign eq = opA == opB;
    assign lt = $signed(opA) < $signed(opB);
    assign ltu = opA < opB;

endmodule

`default_nettype wire

//--- design/coreController.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defines.svh"

module coreController import rvCorePkg::*; (
    input  logic             clk,
    input  logic             rstN,
    decodeIf.ctrl            dec,
    stepIf.ctrl              step,
    input  logic [31:0]      memAddr,
    input  logic [`XLEN-1:0] wdata,
    input  logic [7:0]       wstrb,
    output logic [31:0]      paddr,
    output logic             psel,
    output logic             penable,
    output logic             pwrite,
    output logic [`XLEN-1:0] pwdata,
    output logic [7:0]       pstrb,
    input  logic             pready,
    input  logic             pslverr,
    output logic             retire,
    output logic             halted,
    output logic             trapIllegal
);
    coreStateT state;
    coreStateT nextState;
    logic      setTrap;
    logic      memPhase;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stReset;
            trapIllegal <= 1'b0;
        end else begin
            state <= nextState;
            if (setTrap)
                trapIllegal <= 1'b1;
        end
    end

    always_comb begin
        nextState = state;
        setTrap = 1'b0;
        retire = 1'b0;
        step.irLoad = 1'b0;
        step.execLatch = 1'b0;
        step.memLatch = 1'b0;
        step.regWrEn = 1'b0;
        step.pcUpdate = 1'b0;
        case (state)
            stReset:      nextState = stFetchSetup;
            stFetchSetup: nextState = stFetchAccess;
            stFetchAccess: begin
                if (pready && pslverr) begin
                    nextState = stHalted;
                    setTrap = 1'b1;
                end else if (pready) begin
                    step.irLoad = 1'b1;
                    nextState = stExecute;
                end
            end
            stExecute: begin
                step.execLatch = 1'b1;
                if (dec.illegal) begin
                    nextState = stHalted;
                    setTrap = 1'b1;
                end else if (dec.memRd || dec.memWr) begin
                    nextState = stMemSetup;
                end else begin
                    nextState = stWriteback;
                end
            end
            stMemSetup: nextState = stMemAccess;
            stMemAccess: begin
                if (pready && pslverr) begin
                    nextState = stHalted;
                    setTrap = 1'b1;
                end else if (pready) begin
                    step.memLatch = 1'b1;
                    nextState = stWriteback;
                end
            end
            stWriteback: begin
                if (dec.ebreak) begin
                    nextState = stHalted; // ebreak does not retire
                end else begin
                    step.regWrEn = dec.regWr;
                    step.pcUpdate = 1'b1;
                    retire = 1'b1;
                    nextState = stFetchSetup;
                end
            end
            default: nextState = stHalted; // only reset leaves
        endcase
    end

    assign psel = state inside {stFetchSetup, stFetchAccess, stMemSetup, stMemAccess};
    assign penable = state inside {stFetchAccess, stMemAccess};
    assign memPhase = state inside {stMemSetup, stMemAccess};
    assign pwrite = memPhase && dec.memWr;
    assign paddr = memAddr; // holds the pc during fetch
    assign pwdata = wdata;
    assign pstrb = pwrite ? wstrb : 8'h00;
    assign halted = state == stHalted;

endmodule

`default_nettype wire

//--- design/coreIfs.sv
`timescale 1ns/1ps
`default_nettype none

interface decodeIf import rvCorePkg::*; ();
    opClassT    opClass;
    aluOpT      aluOp;
    logic       aluASrcPc; // operand a is the pc
    logic       aluBSrc;   // operand b is the immediate
    xlenT       imm;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    logic       regWr;
    logic       memRd;
    logic       memWr;
    memSizeT    memSize;
    logic       memUnsigned;
    branchTypeT branch;
    logic       isWord;
    logic       ebreak;
    logic       illegal;

    modport decoder (
        output opClass, aluOp, aluASrcPc, aluBSrc, imm, rs1, rs2, rd,
        output regWr, memRd, memWr, memSize, memUnsigned, branch, isWord, ebreak, illegal
    );
    modport ctrl (input memRd, memWr, regWr, ebreak, illegal);
    modport dp (
        input opClass, aluOp, aluASrcPc, aluBSrc, imm, rs1, rs2, rd,
        input memSize, memUnsigned, branch, isWord
    );
endinterface

interface stepIf ();
    logic irLoad;
    logic execLatch;
    logic memLatch;
    logic regWrEn;
    logic pcUpdate;

    modport ctrl (output irLoad, execLatch, memLatch, regWrEn, pcUpdate);
    modport dp (input irLoad, execLatch, memLatch, regWrEn, pcUpdate);
endinterface

`default_nettype wire

//--- design/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defines.svh"

module instrDecoder import rvCorePkg::*; (
    input  logic [31:0] instr,
    decodeIf.decoder    dec
);
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       badFunct;
    immFmtT     fmt;

    function automatic aluOpT aluFromFunct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? aluSub : aluAdd;
            3'b001:  return aluSll;
            3'b010:  return aluSlt;
            3'b011:  return aluSltu;
            3'b100:  return aluXor;
            3'b101:  return alt ? aluSra : aluSrl;
            3'b110:  return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign dec.rs1 = instr[19:15];
    assign dec.rs2 = instr[24:20];
    assign dec.rd = instr[11:7];
    assign dec.memSize = memSizeT'(funct3[1:0]);
    assign dec.memUnsigned = funct3[2];

    always_comb begin
        dec.opClass = opOpImm;
        dec.aluOp = aluAdd;
        dec.aluASrcPc = 1'b0;
        dec.aluBSrc = 1'b1;
        dec.regWr = 1'b0;
        dec.memRd = 1'b0;
        dec.memWr = 1'b0;
        dec.branch = brNone;
        dec.isWord = 1'b0;
        dec.ebreak = 1'b0;
        fmt = immI;
        badFunct = 1'b0;
        case (instr[6:2])
            5'b00000: begin // loads, lwu included
                dec.opClass = opLoad;
                dec.regWr = 1'b1;
                dec.memRd = 1'b1;
                badFunct = funct3 == 3'b111;
            end
            5'b01000: begin
                dec.opClass = opStore;
                dec.memWr = 1'b1;
                fmt = immS;
                badFunct = funct3[2];
            end
            5'b00100: begin
                dec.opClass = opOpImm;
                dec.regWr = 1'b1;
                dec.aluOp = aluFromFunct3(funct3, funct3 == 3'b101 && instr[30]);
                if (funct3 == 3'b001)
                    badFunct = instr[31:26] != 6'b000000; // 6-bit shamt
                else if (funct3 == 3'b101)
                    badFunct = instr[31:26] != 6'b000000 && instr[31:26] != 6'b010000;
            end
            5'b00110: begin
                dec.opClass = opOpImmW;
                dec.regWr = 1'b1;
                dec.isWord = 1'b1;
                dec.aluOp = aluFromFunct3(funct3, funct3 == 3'b101 && instr[30]);
                case (funct3)
                    3'b000:  badFunct = 1'b0;
                    3'b001:  badFunct = funct7 != 7'b0000000;
                    3'b101:  badFunct = funct7 != 7'b0000000 && funct7 != 7'b0100000;
                    default: badFunct = 1'b1;
                endcase
            end
            5'b01100, 5'b01110: begin
                dec.opClass = instr[3] ? opOpW : opOp;
                dec.regWr = 1'b1;
                dec.aluBSrc = 1'b0;
                dec.isWord = instr[3];
                dec.aluOp = aluFromFunct3(funct3, funct7[5]);
                badFunct = !(funct7 == 7'b0000000 ||
                             (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
                if (instr[3] && funct3 != 3'b000 && funct3 != 3'b001 && funct3 != 3'b101)
                    badFunct = 1'b1;
            end
            5'b01101: begin
                dec.opClass = opLui;
                dec.regWr = 1'b1;
                dec.aluOp = aluPassB;
                fmt = immU;
            end
            5'b00101: begin
                dec.opClass = opAuipc;
                dec.regWr = 1'b1;
                dec.aluASrcPc = 1'b1;
                fmt = immU;
            end
            5'b11011: begin
                dec.opClass = opJal;
                dec.regWr = 1'b1;
                dec.aluASrcPc = 1'b1;
                dec.branch = brJal;
                fmt = immJ;
            end
            5'b11001: begin
                dec.opClass = opJalr;
                dec.regWr = 1'b1;
                dec.branch = brJalr;
                badFunct = funct3 != 3'b000;
            end
            5'b11000: begin
                dec.opClass = opBranch;
                dec.aluBSrc = 1'b0;
                dec.aluOp = aluSub;
                fmt = immB;
                case (funct3)
                    3'b000:  dec.branch = brEq;
                    3'b001:  dec.branch = brNe;
                    3'b100:  dec.branch = brLt;
                    3'b101:  dec.branch = brGe;
                    3'b110:  dec.branch = brLtu;
                    3'b111:  dec.branch = brGeu;
                    default: badFunct = 1'b1;
                endcase
            end
            5'b11100: begin // only ebreak is supported
                dec.opClass = opSystem;
                dec.ebreak = instr == 32'h0010_0073;
                badFunct = instr != 32'h0010_0073;
            end
            default: badFunct = 1'b1;
        endcase
        dec.illegal = badFunct || instr[1:0] != 2'b11;
    end

    always_comb begin
        case (fmt)
            immS:    dec.imm = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            immB:    dec.imm = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25],
                                instr[11:8], 1'b0};
            immU:    dec.imm = {{(`XLEN-32){instr[31]}}, instr[31:12], 12'b0};
            immJ:    dec.imm = {{(`XLEN-20){instr[31]}}, instr[19:12], instr[20],
                                instr[30:21], 1'b0};
            default: dec.imm = {{(`XLEN-12){instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

`default_nettype wire

//--- design/perfCounter.sv
`timescale 1ns/1ps
`default_nettype none

module perfCounter (
    input  logic        clk,
    input  logic        rstN,
    input  logic        retire,
    input  logic        halted,
    output logic [63:0] cycleCount,
    output logic [63:0] instretCount
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            cycleCount <= 64'd0;
            instretCount <= 64'd0;
        end else begin
            if (!halted)
                cycleCount <= cycleCount + 64'd1; // frozen once halted
            if (retire)
                instretCount <= instretCount + 64'd1;
        end
    end

endmodule

`default_nettype wire

//--- design/rvCorePkg.sv
`default_nettype none

`include "rvCore_defines.svh"

package rvCorePkg;

    typedef logic [`XLEN-1:0] xlenT;

    typedef enum logic [3:0] {
        opLoad, opStore, opOpImm, opOpImmW, opOp, opOpW,
        opLui, opAuipc, opJal, opJalr, opBranch, opSystem
    } opClassT;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
        aluSrl, aluSra, aluOr, aluAnd, aluPassB
    } aluOpT;

    typedef enum logic [3:0] {
        brNone, brJal, brJalr, brEq, brNe, brLt, brGe, brLtu, brGeu
    } branchTypeT;

    typedef enum logic [2:0] {
        immI, immS, immB, immU, immJ
    } immFmtT;

    // matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        memByte, memHalf, memWord, memDouble
    } memSizeT;

    typedef enum logic [2:0] {
        stReset, stFetchSetup, stFetchAccess, stExecute,
        stMemSetup, stMemAccess, stWriteback, stHalted
    } coreStateT;

endpackage

`default_nettype wire

//--- design/rvCoreTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defines.svh"

module rvCoreTop (
    input  logic             clk,
    input  logic             rstN,
    output logic [31:0]      paddr,
    output logic             psel,
    output logic             penable,
    output logic             pwrite,
    output logic [`XLEN-1:0] pwdata,
    output logic [7:0]       pstrb,
    input  logic [`XLEN-1:0] prdata,
    input  logic             pready,
    input  logic             pslverr,
    output logic             halted,
    output logic             trapIllegal,
    output logic [63:0]      cycleCount,
    output logic [63:0]      instretCount
);
    logic [31:0]      memAddr;
    logic [`XLEN-1:0] wdata;
    logic [7:0]       wstrb;
    logic [31:0]      instr;
    logic             retire;

    decodeIf decBus ();
    stepIf   stepBus ();

    coreController uCtrl (
        .clk         (clk),
        .rstN        (rstN),
        .dec         (decBus.ctrl),
        .step        (stepBus.ctrl),
        .memAddr     (memAddr),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .pstrb       (pstrb),
        .pready      (pready),
        .pslverr     (pslverr),
        .retire      (retire),
        .halted      (halted),
        .trapIllegal (trapIllegal)
    );

    instrDecoder uDec (
        .instr (instr),
        .dec   (decBus.decoder)
    );

    rvDatapath uDp (
        .clk     (clk),
        .rstN    (rstN),
        .dec     (decBus.dp),
        .step    (stepBus.dp),
        .rdata   (prdata),
        .memAddr (memAddr),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .instr   (instr)
    );

    perfCounter uPerf (
        .clk          (clk),
        .rstN         (rstN),
        .retire       (retire),
        .halted       (halted),
        .cycleCount   (cycleCount),
        .instretCount (instretCount)
    );

endmodule

`default_nettype wire

//--- design/rvCore_defines.svh
`ifndef RVCORE_DEFINES_SVH
`define RVCORE_DEFINES_SVH

// data path width
`define XLEN 64

// architectural integer registers
`define REG_COUNT 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

//--- design/rvDatapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defines.svh"

module rvDatapath import rvCorePkg::*; (
    input  logic              clk,
    input  logic              rstN,
    decodeIf.dp               dec,
    stepIf.dp                 step,
    input  logic [`XLEN-1:0]  rdata,
    output logic [31:0]       memAddr,
    output logic [`XLEN-1:0]  wdata,
    output logic [7:0]        wstrb,
    output logic [31:0]       instr
);
    logic [31:0]      pc;
    logic [31:0]      pcPlus4;
    logic [31:0]      nextPc;
    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic [`XLEN-1:0] rs1Val;
    logic [`XLEN-1:0] rs2Val;
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] aluRes;
    logic [`XLEN-1:0] aluResQ;
    logic [`XLEN-1:0] loadShift;
    logic [`XLEN-1:0] loadExt;
    logic [`XLEN-1:0] loadQ;
    logic [`XLEN-1:0] wbData;
    logic [7:0]       sizeMask;
    logic             eq;
    logic             lt;
    logic             ltu;
    logic             taken;

    assign rs1Val = (dec.rs1 == 5'd0) ? '0 : regs[dec.rs1]; // x0 reads zero
    assign rs2Val = (dec.rs2 == 5'd0) ? '0 : regs[dec.rs2];
    assign opA = dec.aluASrcPc ? {{(`XLEN-32){1'b0}}, pc} : rs1Val;
    assign opB = dec.aluBSrc ? dec.imm : rs2Val;

    aluUnit uAlu (
        .opA    (opA),
        .opB    (opB),
        .op     (dec.aluOp),
        .isWord (dec.isWord),
        .result (aluRes),
        .eq     (eq),
        .lt     (lt),
        .ltu    (ltu)
    );

    always_comb begin
        case (dec.branch)
            brJal:   taken = 1'b1;
            brEq:    taken = eq;
            brNe:    taken = !eq;
            brLt:    taken = lt;
            brGe:    taken = !lt;
            brLtu:   taken = ltu;
            brGeu:   taken = !ltu;
            default: taken = 1'b0;
        endcase
    end

    assign pcPlus4 = pc + 32'd4;
    assign nextPc = (dec.branch == brJalr) ? (aluResQ[31:0] & ~32'd1) :
                    taken ? (pc + dec.imm[31:0]) : pcPlus4;

    // memAddr follows the pc between instructions, the ea after execute
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= `RESET_PC;
            memAddr <= `RESET_PC;
        end else if (step.pcUpdate) begin
            pc <= nextPc;
            memAddr <= nextPc;
        end else if (step.execLatch) begin
            memAddr <= aluRes[31:0];
        end
    end

    always_ff @(posedge clk) begin
        if (step.irLoad)
            instr <= pc[2] ? rdata[63:32] : rdata[31:0]; // upper or lower word
        if (step.execLatch)
            aluResQ <= aluRes;
        if (step.memLatch)
            loadQ <= loadExt;
    end

    always_comb begin
        loadShift = rdata >> {memAddr[2:0], 3'b000};
        case (dec.memSize)
            memByte: loadExt = dec.memUnsigned ? {{(`XLEN-8){1'b0}}, loadShift[7:0]}
                                               : {{(`XLEN-8){loadShift[7]}}, loadShift[7:0]};
            memHalf: loadExt = dec.memUnsigned ? {{(`XLEN-16){1'b0}}, loadShift[15:0]}
                                               : {{(`XLEN-16){loadShift[15]}}, loadShift[15:0]};
            memWord: loadExt = dec.memUnsigned ? {{(`XLEN-32){1'b0}}, loadShift[31:0]}
                                               : {{(`XLEN-32){loadShift[31]}}, loadShift[31:0]};
            default: loadExt = loadShift;
        endcase
    end

    // store lanes
    always_comb begin
        case (dec.memSize)
            memByte: sizeMask = 8'h01;
            memHalf: sizeMask = 8'h03;
            memWord: sizeMask = 8'h0f;
            default: sizeMask = 8'hff;
        endcase
    end

    assign wstrb = sizeMask << memAddr[2:0];
    assign wdata = rs2Val << {memAddr[2:0], 3'b000};

    always_comb begin
        case (dec.opClass)
            opJal, opJalr: wbData = {{(`XLEN-32){1'b0}}, pcPlus4}; // link
            opLoad:        wbData = loadQ;
            default:       wbData = aluResQ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (step.regWrEn && dec.rd != 5'd0)
            regs[dec.rd] <= wbData;
    end

endmodule

`default_nettype wire

//--- rvCore.f
+incdir+design
design/rvCorePkg.sv
design/coreIfs.sv
design/instrDecoder.sv
design/aluUnit.sv
design/rvDatapath.sv
design/coreController.sv
design/perfCounter.sv
design/rvCoreTop.sv
tests/tbClock.sv
tests/apbMemModel.sv
tests/rvCoreTb.sv

//--- tests/apbMemModel.sv
`timescale 1ns/1ps
`default_nettype none

module apbMemModel #(
    parameter int seed = 53
) (
    input  logic        clk,
    input  logic [31:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [63:0] pwdata,
    input  logic [7:0]  pstrb,
    output logic [63:0] prdata,
    output logic        pready,
    output logic        pslverr
);
    logic [63:0] mem [1024]; // 8 KB of doublewords

    assign pslverr = 1'b0;

    // one process so the wait-state sequence comes from a single seeded stream
    initial begin
        int rngSeed;
        int waitLeft;
        rngSeed = seed;
        void'($urandom(rngSeed));
        pready = 1'b0;
        prdata = '0;
        waitLeft = $urandom % 4;
        forever begin
            @(posedge clk);
            pready <= 1'b0;
            if (psel && penable && !pready) begin
                if (waitLeft == 0) begin
                    pready <= 1'b1;
                    prdata <= mem[paddr[12:3]];
                    if (pwrite) begin
                        for (int b = 0; b < 8; b++) begin
                            if (pstrb[b])
                                mem[paddr[12:3]][8*b +: 8] <= pwdata[8*b +: 8];
                        end
                    end
                    waitLeft = $urandom % 4; // 0 to 3 wait states
                end else begin
                    waitLeft = waitLeft - 1;
                end
            end
        end
    end

    task automatic clearMem();
        for (int i = 0; i < 1024; i++)
            mem[i] = '0;
    endtask

    task automatic writeInstr(input logic [31:0] addr, input logic [31:0] word);
        if (addr[2])
            mem[addr[12:3]][63:32] = word;
        else
            mem[addr[12:3]][31:0] = word;
    endtask

    function automatic logic [63:0] peek(input logic [31:0] addr);
        return mem[addr[12:3]];
    endfunction

endmodule

`default_nettype wire

//--- tests/rvCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defines.svh"

module rvCoreTb;
    // 80 instructions over all runs, 40 cycles each, plus 100 cycles per run
    localparam int watchdogNs = (80 * 40 + 4 * 100) * 10;

    logic        clk;
    logic        rstN;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [63:0] pwdata;
    logic [7:0]  pstrb;
    logic [63:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        halted;
    logic        trapIllegal;
    logic [63:0] cycleCount;
    logic [63:0] instretCount;

    int          errors;
    logic [31:0] prog [$];
    logic [31:0] wrAddr [$];
    logic [7:0]  wrStrb [$];
    logic        prevSel;
    logic        prevEn;
    logic        prevRdy;
    logic        prevWrite;
    logic [31:0] prevAddr;
    logic [63:0] prevWdata;
    logic [7:0]  prevStrb;

    tbClock uClk (.clk(clk));

    apbMemModel #(.seed(53)) uMem (
        .clk(clk), .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    rvCoreTop u_dut (
        .clk(clk), .rstN(rstN), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata),
        .pready(pready), .pslverr(pslverr), .halted(halted), .trapIllegal(trapIllegal),
        .cycleCount(cycleCount), .instretCount(instretCount)
    );

    task automatic reportMismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
        errors++;
        $display("FAIL %s: got %h expected %h", name, got, exp);
    endtask

    task automatic reportProblem(input string msg);
        errors++;
        $display("ERROR %s", msg);
    endtask

    // instruction encoders
    function automatic logic [31:0] encI(int imm, int rs1, int f3, int rd, logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] encR(int f7, int rs2, int rs1, int f3, int rd,
                                         logic [6:0] opc);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] encS(int imm, int rs2, int rs1, int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] encB(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] encU(int imm20, int rd, logic [6:0] opc);
        return {imm20[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] encJ(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    // protocol checks over the whole run
    always @(posedge clk) begin
        if (rstN) begin
            if (penable && !prevEn)
                assert (prevSel && psel) else reportProblem("penable rose without a setup phase");
            if (prevEn && !prevRdy && penable) begin
                assert (paddr == prevAddr) else reportMismatch("paddr", paddr, prevAddr);
                assert (pwrite == prevWrite) else reportMismatch("pwrite", pwrite, prevWrite);
                assert (pwdata == prevWdata) else reportMismatch("pwdata", pwdata, prevWdata);
                assert (pstrb == prevStrb) else reportMismatch("pstrb", pstrb, prevStrb);
            end
            if (psel && pwrite)
                assert (pstrb != 8'h00) else reportProblem("write issued with empty pstrb");
            if (halted)
                assert (!psel) else reportProblem("psel raised while halted");
            if (psel && penable && pready && pwrite) begin
                wrAddr.push_back(paddr);
                wrStrb.push_back(pstrb);
            end
        end
        prevSel <= psel;
        prevEn <= penable;
        prevRdy <= pready;
        prevWrite <= pwrite;
        prevAddr <= paddr;
        prevWdata <= pwdata;
        prevStrb <= pstrb;
    end

    task automatic startProgram();
        @(posedge clk);
        rstN <= 1'b0;
        uMem.clearMem();
        foreach (prog[i])
            uMem.writeInstr(4 * i, prog[i]);
        wrAddr.delete();
        wrStrb.delete();
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);
        assert (!psel) else reportMismatch("psel", psel, 0);
        assert (!penable) else reportMismatch("penable", penable, 0);
        assert (!halted) else reportMismatch("halted", halted, 0);
        assert (!trapIllegal) else reportMismatch("trapIllegal", trapIllegal, 0);
        assert (cycleCount == 0) else reportMismatch("cycleCount", cycleCount, 0);
        assert (instretCount == 0) else reportMismatch("instretCount", instretCount, 0);
        do @(posedge clk); while (!psel);
        assert (paddr == `RESET_PC) else reportMismatch("paddr", paddr, `RESET_PC);
        assert (!pwrite && !penable) else reportProblem("first access is not a read setup");
    endtask

    task automatic finishProgram(input int retired, input logic trapExp);
        logic [63:0] frozen;
        while (!halted) @(posedge clk);
        assert (trapIllegal == trapExp) else reportMismatch("trapIllegal", trapIllegal, trapExp);
        assert (instretCount == retired) else reportMismatch("instretCount", instretCount, retired);
        // at least four cycles per retired instruction
        assert (cycleCount >= 4 * retired + 3)
            else reportMismatch("cycleCount minimum", cycleCount, 4 * retired + 3);
        frozen = cycleCount;
        repeat (5) @(posedge clk);
        assert (cycleCount == frozen) else reportMismatch("cycleCount", cycleCount, frozen);
    endtask

    task automatic checkMem(input logic [31:0] addr, input logic [63:0] exp);
        logic [63:0] got;
        got = uMem.peek(addr);
        assert (got == exp) else reportMismatch($sformatf("mem[%h]", addr), got, exp);
    endtask

    initial begin
        #(watchdogNs);
        $display("watchdog expired before the core halted");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        errors = 0;
        rstN = 1'b0;

        // arithmetic and immediates, results at 0x1000
        prog = {encU(1, 10, 7'h37), encI(-5, 0, 0, 1, 7'h13), encU(20'h80000, 2, 7'h37),
                encU(2, 3, 7'h17), encI(40, 1, 1, 4, 7'h13), encI(12'h400 | 28, 2, 5, 5, 7'h13),
                encR(0, 3, 1, 0, 6, 7'h33), encR(7'h20, 1, 3, 0, 7, 7'h33),
                encU(20'h7ffff, 8, 7'h37), encR(0, 8, 8, 0, 9, 7'h3b),
                encI(-1, 2, 0, 11, 7'h1b), encR(0, 3, 1, 2, 12, 7'h33),
                encR(0, 3, 1, 3, 13, 7'h33)};
        prog.push_back(encS(0, 3, 10, 3));
        prog.push_back(encS(8, 4, 10, 3));
        prog.push_back(encS(16, 5, 10, 3));
        prog.push_back(encS(24, 6, 10, 3));
        prog.push_back(encS(32, 7, 10, 3));
        prog.push_back(encS(40, 9, 10, 3));
        prog.push_back(encS(48, 11, 10, 3));
        prog.push_back(encS(56, 12, 10, 3));
        prog.push_back(encS(64, 13, 10, 3));
        prog.push_back(32'h0010_0073);
        startProgram();
        finishProgram(22, 1'b0);
        checkMem(32'h1000, 64'h0000_0000_0000_200c); // auipc at pc 12
        checkMem(32'h1008, 64'hffff_fb00_0000_0000);
        checkMem(32'h1010, 64'hffff_ffff_ffff_fff8);
        checkMem(32'h1018, 64'h0000_0000_0000_2007);
        checkMem(32'h1020, 64'h0000_0000_0000_2011);
        checkMem(32'h1028, 64'hffff_ffff_ffff_e000); // addw wraps negative
        checkMem(32'h1030, 64'h0000_0000_7fff_ffff); // addiw wraps positive
        checkMem(32'h1038, 64'h1);
        checkMem(32'h1040, 64'h0);

        // branches and jumps
        prog = {encU(1, 10, 7'h37), encI(0, 0, 0, 1, 7'h13), encI(10, 0, 0, 2, 7'h13),
                encI(1, 1, 0, 1, 7'h13), encB(-4, 2, 1, 1), encS(0, 1, 10, 3),
                encB(8, 2, 1, 0), encI(1, 0, 0, 5, 7'h13), encB(8, 0, 1, 0),
                encI(2, 0, 0, 6, 7'h13), encI(-1, 0, 0, 7, 7'h13), encB(8, 7, 2, 6),
                encI(4, 6, 0, 6, 7'h13), encB(8, 2, 7, 5), encB(8, 7, 2, 5),
                encI(8, 6, 0, 6, 7'h13), encB(8, 2, 7, 6), encJ(12, 8),
                encI(16, 6, 0, 6, 7'h13), encI(16, 6, 0, 6, 7'h13), encI(96, 0, 0, 9, 7'h13),
                encI(0, 9, 0, 11, 7'h67), encI(32, 6, 0, 6, 7'h13), encI(64, 6, 0, 6, 7'h13),
                encS(8, 6, 10, 3), encS(16, 8, 10, 3), encS(24, 11, 10, 3), 32'h0010_0073};
        startProgram();
        finishProgram(38, 1'b0);
        checkMem(32'h1000, 64'd10);
        checkMem(32'h1008, 64'd2); // skipped paths add to x6
        checkMem(32'h1010, 64'd72); // jal link
        checkMem(32'h1018, 64'd88); // jalr link

        // byte and half stores, sign and zero extending loads
        prog = {encU(1, 10, 7'h37), encI(-128, 0, 0, 1, 7'h13), encU(8, 2, 7'h37),
                encI(12'h123, 2, 0, 2, 7'h13), encS(3, 1, 10, 0), encS(6, 2, 10, 1),
                encI(3, 10, 0, 3, 7'h03), encI(3, 10, 4, 4, 7'h03), encI(6, 10, 1, 5, 7'h03),
                encI(6, 10, 5, 6, 7'h03), encI(4, 10, 2, 7, 7'h03), encS(16, 3, 10, 3),
                encS(24, 4, 10, 3), encS(32, 5, 10, 3), encS(40, 6, 10, 3),
                encS(48, 7, 10, 3), 32'h0010_0073};
        startProgram();
        finishProgram(16, 1'b0);
        if (wrAddr.size() < 2) begin
            reportProblem("byte and half stores were not seen on the bus");
        end else begin
            assert (wrAddr[0] == 32'h1003) else reportMismatch("paddr sb", wrAddr[0], 32'h1003);
            assert (wrStrb[0] == 8'h08) else reportMismatch("pstrb sb", wrStrb[0], 8'h08);
            assert (wrAddr[1] == 32'h1006) else reportMismatch("paddr sh", wrAddr[1], 32'h1006);
            assert (wrStrb[1] == 8'hc0) else reportMismatch("pstrb sh", wrStrb[1], 8'hc0);
        end
        checkMem(32'h1010, 64'hffff_ffff_ffff_ff80);
        checkMem(32'h1018, 64'h0000_0000_0000_0080);
        checkMem(32'h1020, 64'hffff_ffff_ffff_8123);
        checkMem(32'h1028, 64'h0000_0000_0000_8123);
        checkMem(32'h1030, 64'hffff_ffff_8123_0000);

        // all-zero word is not a valid encoding
        prog = {32'h0000_0000};
        startProgram();
        finishProgram(0, 1'b1);

        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int halfPeriodNs = 5
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(halfPeriodNs) clk = ~clk; // 10 ns period

endmodule

`default_nettype wire
